// ==== logic/issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// producer tag carried in the wait field
`define ISSUE_TAG_W   4
// word address into the data memory
`define ISSUE_ADDR_W  6
`define ISSUE_DATA_W  16

// entries per issue queue, one slot always kept free
`define ISSUE_DEPTH   4
`define ISSUE_PORTS   2

`endif

// ==== logic/mem_pkg.sv ====
`default_nettype none

`include "issue_consts.svh"

package mem_pkg;

    // one request toward the shared data memory
    typedef struct packed {
        logic                     wr;     // 1 = store
        logic [`ISSUE_ADDR_W-1:0] addr;
        logic [`ISSUE_DATA_W-1:0] wdata;
    } mem_req_t;

    // load response, one cycle after grant
    typedef struct packed {
        logic                     valid;
        logic [`ISSUE_DATA_W-1:0] rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== logic/issue_pkg.sv ====
`default_nettype none

`include "issue_consts.svh"

package issue_pkg;

    // M section, rewritten on tag broadcast
    typedef struct packed {
        logic                    waiting;
        logic [`ISSUE_TAG_W-1:0] tag;     // producer we wait on
    } wait_field_t;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_opc_e;

    typedef struct packed {
        logic [`ISSUE_TAG_W-1:0]  dst_tag;
        logic [`ISSUE_ADDR_W-1:0] addr;
        logic [12:0]              pad;
    } load_view_t;

    typedef struct packed {
        logic [`ISSUE_ADDR_W-1:0] addr;
        logic [`ISSUE_DATA_W-1:0] data;
        logic                     pad;
    } store_view_t;

    // N section, meaning depends on opc
    typedef union packed {
        load_view_t  ld;
        store_view_t st;
    } mem_op_u;

    typedef struct packed {
        mem_opc_e opc;
        mem_op_u  u;
    } mem_op_t;

    typedef struct packed {
        wait_field_t wt;
        mem_op_t     op;
    } queue_entry_t;

endpackage

`default_nettype wire

// ==== logic/tag_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module tag_queue
    import issue_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr,
    input  queue_entry_t                    din,
    input  logic                            rd,
    input  logic [`ISSUE_DEPTH-1:0]         modify,
    input  wait_field_t [`ISSUE_DEPTH-1:0]  new_wait,
    output logic                            full,
    output logic                            empty,
    output wait_field_t [`ISSUE_DEPTH-1:0]  old_wait,
    output queue_entry_t                    dout
);

    logic [`ISSUE_DEPTH-1:0] wr_ptr;
    logic [`ISSUE_DEPTH-1:0] rd_ptr;
    logic [`ISSUE_DEPTH-1:0] wr_ptr_rot;
    logic [`ISSUE_DEPTH-1:0] rd_ptr_rot;
    logic                    do_wr;
    logic                    do_rd;

    wait_field_t wait_q [`ISSUE_DEPTH];
    mem_op_t     op_q [`ISSUE_DEPTH];

    // rotate left by one
    assign wr_ptr_rot = {wr_ptr[`ISSUE_DEPTH-2:0], wr_ptr[`ISSUE_DEPTH-1]};
    assign rd_ptr_rot = {rd_ptr[`ISSUE_DEPTH-2:0], rd_ptr[`ISSUE_DEPTH-1]};

    assign empty = (rd_ptr == wr_ptr);
    assign full  = (rd_ptr == wr_ptr_rot);  // writer one step behind reader

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= {{(`ISSUE_DEPTH-1){1'b0}}, 1'b1};
            rd_ptr <= {{(`ISSUE_DEPTH-1){1'b0}}, 1'b1};
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr_rot;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr_rot;
            end
        end
    end

    // write has priority over a wake-up rewrite of the same slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            if (do_wr && wr_ptr[i]) begin
                wait_q[i] <= din.wt;
                op_q[i]   <= din.op;
            end else if (modify[i]) begin
                wait_q[i] <= new_wait[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            old_wait[i] = wait_q[i];
        end
    end

    // one-hot select of the head
    always_comb begin
        dout = '0;
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            if (rd_ptr[i]) begin
                dout.wt = wait_q[i];
                dout.op = op_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/wakeup_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module wakeup_issue
    import mem_pkg::*;
    import issue_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     enq_valid,
    output logic                     enq_ready,
    input  queue_entry_t             enq_entry,
    input  logic                     wake_valid,
    input  logic [`ISSUE_TAG_W-1:0]  wake_tag,
    output logic                     req_valid,
    output mem_req_t                 req,
    input  logic                     grant
);

    queue_entry_t                    enq_in;
    queue_entry_t                    head;
    wait_field_t [`ISSUE_DEPTH-1:0]  old_wait;
    wait_field_t [`ISSUE_DEPTH-1:0]  new_wait;
    logic [`ISSUE_DEPTH-1:0]         modify;
    logic                            full;
    logic                            empty;
    logic                            store;

    // tag match against every queued entry
    always_comb begin
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            modify[i] = wake_valid && old_wait[i].waiting && (old_wait[i].tag == wake_tag);
            new_wait[i].waiting = 1'b0;
            new_wait[i].tag     = old_wait[i].tag;
        end
    end

    // incoming entry sees the same broadcast
    always_comb begin
        enq_in = enq_entry;
        if (wake_valid && enq_entry.wt.waiting && (enq_entry.wt.tag == wake_tag)) begin
            enq_in.wt.waiting = 1'b0;
        end
    end

    assign enq_ready = !full;
    assign req_valid = !empty && !head.wt.waiting;
    assign store     = (head.op.opc == OP_STORE);

    always_comb begin
        req.wr    = store;
        req.addr  = store ? head.op.u.st.addr : head.op.u.ld.addr;
        req.wdata = store ? head.op.u.st.data : '0;
    end

    tag_queue u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (enq_valid),
        .din      (enq_in),
        .rd       (req_valid && grant),  // pop on accepted issue
        .modify   (modify),
        .new_wait (new_wait),
        .full     (full),
        .empty    (empty),
        .old_wait (old_wait),
        .dout     (head)
    );

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module mem_arbiter
    import mem_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [`ISSUE_PORTS-1:0]           req_valid,
    input  mem_req_t [`ISSUE_PORTS-1:0]       req,
    output logic [`ISSUE_PORTS-1:0]           grant,
    output logic                              mem_valid,
    output mem_req_t                          mem_req,
    output logic [$clog2(`ISSUE_PORTS)-1:0]   resp_port
);

    localparam int PORT_W = $clog2(`ISSUE_PORTS);

    logic [PORT_W-1:0] prio;  // port searched first
    logic [PORT_W-1:0] win;

    always_comb begin
        int idx;
        grant = '0;
        win   = '0;
        for (int k = 0; k < `ISSUE_PORTS; k++) begin
            idx = int'(prio) + k;
            if (idx >= `ISSUE_PORTS) begin
                idx = idx - `ISSUE_PORTS;
            end
            if (req_valid[idx] && (grant == '0)) begin
                grant[idx] = 1'b1;
                win        = PORT_W'(idx);
            end
        end
    end

    assign mem_valid = |grant;
    assign mem_req   = req[win];

    // priority moves just past the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio      <= '0;
            resp_port <= '0;
        end else if (mem_valid) begin
            prio      <= (int'(win) == `ISSUE_PORTS-1) ? '0 : win + 1'b1;
            resp_port <= win;
        end
    end

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module data_mem
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      mem_valid,
    input  mem_req_t  mem_req,
    output mem_resp_t resp
);

    logic [`ISSUE_DATA_W-1:0] mem [2**`ISSUE_ADDR_W];

    // stores land at the grant edge
    always_ff @(posedge clk) begin
        if (mem_valid && mem_req.wr) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // load data one cycle after grant
    always_ff @(posedge clk) begin
        resp.valid <= mem_valid && !mem_req.wr;
        resp.rdata <= mem[mem_req.addr];
    end

endmodule

`default_nettype wire

// ==== logic/mem_issue_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module mem_issue_top
    import mem_pkg::*;
    import issue_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`ISSUE_PORTS-1:0]       enq_valid,
    output logic [`ISSUE_PORTS-1:0]       enq_ready,
    input  queue_entry_t [`ISSUE_PORTS-1:0] enq_entry,
    input  logic                          wake_valid,
    input  logic [`ISSUE_TAG_W-1:0]       wake_tag,
    output logic [`ISSUE_PORTS-1:0]       resp_valid,
    output logic [`ISSUE_DATA_W-1:0]      resp_data
);

    logic [`ISSUE_PORTS-1:0]              req_valid;
    logic [`ISSUE_PORTS-1:0]              grant;
    mem_req_t [`ISSUE_PORTS-1:0]          req;
    logic                                 mem_valid;
    mem_req_t                             mem_req;
    mem_resp_t                            resp;
    logic [$clog2(`ISSUE_PORTS)-1:0]      resp_port;

    for (genvar p = 0; p < `ISSUE_PORTS; p++) begin : g_port
        wakeup_issue u_issue (
            .clk        (clk),
            .rst_n      (rst_n),
            .enq_valid  (enq_valid[p]),
            .enq_ready  (enq_ready[p]),
            .enq_entry  (enq_entry[p]),
            .wake_valid (wake_valid),   // broadcast to all ports
            .wake_tag   (wake_tag),
            .req_valid  (req_valid[p]),
            .req        (req[p]),
            .grant      (grant[p])
        );

        assign resp_valid[p] = resp.valid && (int'(resp_port) == p);
    end

    assign resp_data = resp.rdata;

    mem_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .grant     (grant),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .resp_port (resp_port)
    );

    data_mem u_mem (
        .clk       (clk),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .resp      (resp)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

endmodule

`default_nettype wire

// ==== test/mem_issue_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module mem_issue_checker
    import mem_pkg::*;
(
    input logic                        clk,
    input logic                        rst_n,
    input logic [`ISSUE_PORTS-1:0]     req_valid,
    input mem_req_t [`ISSUE_PORTS-1:0] req,
    input logic [`ISSUE_PORTS-1:0]     grant,
    input logic                        full,
    input logic                        empty
);

    int assert_fails = 0;  // read back by the testbench

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else begin
            $error("grant is not one-hot");
            assert_fails++;
        end

    a_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
        (grant & ~req_valid) == '0)
        else begin
            $error("grant without a request");
            assert_fails++;
        end

    a_full_empty: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
        else begin
            $error("queue full and empty at once");
            assert_fails++;
        end

    // a losing port keeps its request until granted
    for (genvar p = 0; p < `ISSUE_PORTS; p++) begin : g_hold
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            req_valid[p] && !grant[p] |=> req_valid[p] && $stable(req[p]))
            else begin
                $error("ungranted request on port %0d changed", p);
                assert_fails++;
            end
    end

endmodule

bind mem_arbiter mem_issue_checker u_arb_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .grant     (grant),
    .full      (1'b0),
    .empty     (1'b1)
);

bind tag_queue mem_issue_checker u_queue_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid ('0),
    .req       ('0),
    .grant     ('0),
    .full      (full),
    .empty     (empty)
);

`default_nettype wire

// ==== test/mem_issue_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_consts.svh"

module mem_issue_tb
    import issue_pkg::*;
();

    localparam int MAX_VEC    = 32;
    localparam int WAIT_LIMIT = 60;

    logic                                   clk;
    logic                                   rst_n;
    logic [`ISSUE_PORTS-1:0]                enq_valid;
    logic [`ISSUE_PORTS-1:0]                enq_ready;
    queue_entry_t [`ISSUE_PORTS-1:0]        enq_entry;
    logic                                   wake_valid;
    logic [`ISSUE_TAG_W-1:0]                wake_tag;
    logic [`ISSUE_PORTS-1:0]                resp_valid;
    logic [`ISSUE_DATA_W-1:0]               resp_data;

    int v_test [MAX_VEC];
    int v_port [MAX_VEC];
    int v_opc  [MAX_VEC];
    int v_wait [MAX_VEC];
    int v_tag  [MAX_VEC];
    int v_addr [MAX_VEC];
    int v_data [MAX_VEC];
    int v_wake [MAX_VEC];
    int v_exp  [MAX_VEC];
    int n_vec;

    logic [`ISSUE_DATA_W-1:0] ref_mem [2**`ISSUE_ADDR_W];  // reference memory
    logic [`ISSUE_DATA_W-1:0] expect_q [`ISSUE_PORTS][$];
    int seen [`ISSUE_PORTS];
    int base_seen [`ISSUE_PORTS];
    int errors;
    int test_errors;
    int tests_passed;
    int tests_failed;

    tb_clock u_clock (.clk(clk));

    mem_issue_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .enq_valid  (enq_valid),
        .enq_ready  (enq_ready),
        .enq_entry  (enq_entry),
        .wake_valid (wake_valid),
        .wake_tag   (wake_tag),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("test %0d %s: ok", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    code;
        string line;
        fd = $fopen("test/mem_issue_vectors.txt", "r");
        n_vec = 0;
        if (fd == 0) begin
            note_failure("could not open the vector file");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                code = $fgets(line, fd);
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_test[n_vec],
                               v_port[n_vec], v_opc[n_vec], v_wait[n_vec], v_tag[n_vec],
                               v_addr[n_vec], v_data[n_vec], v_wake[n_vec], v_exp[n_vec]);
                if (code == 9) begin  // comment and blank lines scan short
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic queue_entry_t build_entry(input int idx);
        queue_entry_t e;
        e = '0;
        e.wt.waiting = v_wait[idx][0];
        e.wt.tag     = `ISSUE_TAG_W'(v_tag[idx]);
        if (v_opc[idx] == 1) begin
            e.op.opc       = OP_STORE;
            e.op.u.st.addr = `ISSUE_ADDR_W'(v_addr[idx]);
            e.op.u.st.data = `ISSUE_DATA_W'(v_data[idx]);
        end else begin
            e.op.opc          = OP_LOAD;
            e.op.u.ld.dst_tag = `ISSUE_TAG_W'(idx);
            e.op.u.ld.addr    = `ISSUE_ADDR_W'(v_addr[idx]);
        end
        return e;
    endfunction

    // stores update the model and loads queue its data
    task automatic record_entry(input int idx);
        if (v_opc[idx] == 1) begin
            ref_mem[v_addr[idx]] = `ISSUE_DATA_W'(v_data[idx]);
        end else begin
            check_value("vector expected data", v_exp[idx], ref_mem[v_addr[idx]]);
            expect_q[v_port[idx]].push_back(ref_mem[v_addr[idx]]);
        end
    endtask

    // b < 0 when the line goes alone
    task automatic enqueue_group(input int a, input int b);
        logic [`ISSUE_PORTS-1:0] need;
        int                      cnt;
        need = '0;
        need[v_port[a]] = 1'b1;
        if (b >= 0) begin
            need[v_port[b]] = 1'b1;
        end
        cnt = 0;
        while (((enq_ready & need) != need) && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if ((enq_ready & need) != need) begin
            note_failure("enq_ready stayed low, an entry was never enqueued");
        end else begin
            enq_entry[v_port[a]] = build_entry(a);
            enq_valid[v_port[a]] = 1'b1;
            record_entry(a);
            if (b >= 0) begin
                enq_entry[v_port[b]] = build_entry(b);
                enq_valid[v_port[b]] = 1'b1;
                record_entry(b);
            end
            @(negedge clk);
            enq_valid = '0;
        end
    endtask

    task automatic send_wake(input int idx);
        repeat (v_wake[idx]) @(negedge clk);
        check_value("responses before wake", seen[v_port[idx]] - base_seen[v_port[idx]], 0);
        wake_valid = 1'b1;
        wake_tag   = `ISSUE_TAG_W'(v_tag[idx]);
        @(negedge clk);
        wake_valid = 1'b0;
    endtask

    function automatic int pending_loads();
        int total;
        total = 0;
        for (int p = 0; p < `ISSUE_PORTS; p++) begin
            total += expect_q[p].size();
        end
        return total;
    endfunction

    task automatic drain();
        int cnt;
        cnt = 0;
        while (pending_loads() != 0 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (pending_loads() != 0) begin
            note_failure("load responses still missing after the timeout");
            for (int p = 0; p < `ISSUE_PORTS; p++) begin
                expect_q[p].delete();
            end
        end
    endtask

    task automatic check_after_reset();
        test_errors = 0;
        check_value("enq_ready", enq_ready, {`ISSUE_PORTS{1'b1}});
        repeat (5) begin
            @(negedge clk);
            check_value("resp_valid", resp_valid, 0);
        end
        finish_test(1, "reset state");
    endtask

    task automatic run_vector_test(input int num, input string name, input bit expect_full);
        int idx_q [$];
        int i;
        int b;
        test_errors = 0;
        for (int p = 0; p < `ISSUE_PORTS; p++) begin
            base_seen[p] = seen[p];
        end
        for (int k = 0; k < n_vec; k++) begin
            if (v_test[k] == num) begin
                idx_q.push_back(k);
            end
        end
        if (idx_q.size() == 0) begin
            note_failure("no vectors found for this test");
        end
        i = 0;
        while (i < idx_q.size()) begin
            b = -1;  // next line on another port shares the cycle
            if (i + 1 < idx_q.size() && v_port[idx_q[i+1]] != v_port[idx_q[i]]) begin
                b = idx_q[i+1];
            end
            enqueue_group(idx_q[i], b);
            i += (b >= 0) ? 2 : 1;
        end
        if (expect_full && idx_q.size() > 0) begin
            check_value("enq_ready", enq_ready[v_port[idx_q[0]]], 0);
        end
        for (int k = 0; k < idx_q.size(); k++) begin
            if (v_wait[idx_q[k]] != 0) begin
                send_wake(idx_q[k]);
            end
        end
        drain();
        finish_test(num, name);
    endtask

    // registered responses settle by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < `ISSUE_PORTS; p++) begin
                if (resp_valid[p]) begin
                    if (expect_q[p].size() == 0) begin
                        note_failure($sformatf("port %0d gave a response nobody asked for", p));
                    end else begin
                        check_value($sformatf("resp_data[%0d]", p), resp_data,
                                    expect_q[p].pop_front());
                        seen[p]++;
                    end
                end
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        enq_valid    = '0;
        enq_entry    = '0;
        wake_valid   = 1'b0;
        wake_tag     = '0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int p = 0; p < `ISSUE_PORTS; p++) begin
            seen[p] = 0;
        end
        load_vectors();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_after_reset();
        run_vector_test(2, "store then load", 1'b0);
        run_vector_test(3, "load waits for tag", 1'b0);
        run_vector_test(4, "waiting head fills queue", 1'b1);
        run_vector_test(5, "loads on both ports", 1'b0);

        if (dut.u_arb.u_arb_check.assert_fails
            + dut.g_port[0].u_issue.u_queue.u_queue_check.assert_fails
            + dut.g_port[1].u_issue.u_queue.u_queue_check.assert_fails != 0) begin
            note_failure("concurrent assertions failed in the bound checker");
        end
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/mem_pkg.sv
logic/issue_pkg.sv
logic/tag_queue.sv
logic/wakeup_issue.sv
logic/mem_arbiter.sv
logic/data_mem.sv
logic/mem_issue_top.sv
test/tb_clock.sv
test/mem_issue_checker.sv
test/mem_issue_tb.sv

// ==== test/mem_issue_vectors.txt ====
// test port opc(1=store) waiting tag addr data wake_after expected_load_data
// all hex; port 0 uses addresses below 0x20, port 1 from 0x20
2 0 1 0 0 04 1234 0 0000
2 0 0 0 0 04 0000 0 1234
3 0 1 0 0 08 a5c3 0 0000
3 0 0 1 3 08 0000 6 a5c3
4 0 0 1 5 04 0000 4 1234
4 0 0 0 0 08 0000 0 a5c3
4 0 0 0 0 04 0000 0 1234
5 0 1 0 0 0c 0f0f 0 0000
5 1 1 0 0 21 beef 0 0000
5 0 0 0 0 0c 0000 0 0f0f
5 1 0 0 0 21 0000 0 beef
5 0 0 0 0 04 0000 0 1234
5 1 0 0 0 21 0000 0 beef
